// ==== verilog/ex_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the execute stage, RV32 only
// High products use a fixed latency of MULT_ITERS cycles
////////////////////////////////////////////////////////////

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and latency
  ////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  // Shift amount comes from the low bits of operand b
  localparam int SHAMT_W    = $clog2(XLEN);

  // One shift-add step per multiplier bit
  localparam int MULT_ITERS = 32;
  localparam int MULT_CNT_W = $clog2(MULT_ITERS);
  // Counter value of the final iteration
  localparam logic [MULT_CNT_W-1:0] MULT_LAST = MULT_CNT_W'(MULT_ITERS - 1);

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ALU operators, the compare group sits at the top
  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    XOR  = 5'd2,
    OR   = 5'd3,
    AND  = 5'd4,
    SLL  = 5'd5,
    SRL  = 5'd6,
    SRA  = 5'd7,
    SLT  = 5'd8,
    SLTU = 5'd9,
    EQ   = 5'd10,
    NE   = 5'd11,
    LT   = 5'd12,
    GE   = 5'd13,
    LTU  = 5'd14,
    GEU  = 5'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  // Multiplier FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ITER = 2'd1,
    DONE = 2'd2
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // Request and write port bundles
  ////////////////////////////////////////////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  typedef struct packed {
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  // Register file write, used by both write ports
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_wr_t;

endpackage

// ==== verilog/ex_alu.sv ====
////////////////////////////////////////////////////////////
// Purely combinational ALU, never stalls
// Shift amount is taken from the low bits of operand b
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t alu_req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  ex_pkg::word_t                op_a;
  ex_pkg::word_t                op_b;
  logic [ex_pkg::SHAMT_W-1:0]   shamt;
  ex_pkg::word_t                sum;
  logic                         cmp_signed;
  logic [ex_pkg::XLEN:0]        diff;
  logic                         is_lt;
  logic                         is_eq;
  logic                         sra_fill;
  logic [ex_pkg::XLEN:0]        shr_ext;
  logic [ex_pkg::XLEN:0]        shr_full;

  assign op_a  = alu_req_i.a;
  assign op_b  = alu_req_i.b;
  assign shamt = op_b[ex_pkg::SHAMT_W-1:0];

  ////////////////////////////////////////////////////////////
  // Adder and shared subtractor
  ////////////////////////////////////////////////////////////

  assign sum = op_a + op_b;

  // Signed compares extend with the sign bit, unsigned with zero
  assign cmp_signed = (alu_req_i.op == ex_pkg::SLT) ||
                      (alu_req_i.op == ex_pkg::LT)  ||
                      (alu_req_i.op == ex_pkg::GE);

  // One extra bit so the borrow gives less-than directly
  assign diff = {cmp_signed & op_a[ex_pkg::XLEN-1], op_a} -
                {cmp_signed & op_b[ex_pkg::XLEN-1], op_b};

  assign is_lt = diff[ex_pkg::XLEN];
  assign is_eq = (op_a == op_b);

  ////////////////////////////////////////////////////////////
  // Right shifter
  ////////////////////////////////////////////////////////////

  // SRL and SRA share one arithmetic shifter, the fill bit selects
  assign sra_fill = (alu_req_i.op == ex_pkg::SRA) & op_a[ex_pkg::XLEN-1];
  assign shr_ext  = {sra_fill, op_a};
  assign shr_full = $signed(shr_ext) >>> shamt;

  ////////////////////////////////////////////////////////////
  // Comparison result
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::EQ:   cmp_result_o = is_eq;
      ex_pkg::NE:   cmp_result_o = ~is_eq;
      // Set-less-than reuses the branch compare
      ex_pkg::SLT,
      ex_pkg::SLTU,
      ex_pkg::LT,
      ex_pkg::LTU:  cmp_result_o = is_lt;
      ex_pkg::GE,
      ex_pkg::GEU:  cmp_result_o = ~is_lt;
      default:      cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ex_pkg::ADD: result_o = sum;
      ex_pkg::SUB: result_o = diff[ex_pkg::XLEN-1:0];
      ex_pkg::XOR: result_o = op_a ^ op_b;
      ex_pkg::OR:  result_o = op_a | op_b;
      ex_pkg::AND: result_o = op_a & op_b;
      ex_pkg::SLL: result_o = op_a << shamt;
      ex_pkg::SRL,
      ex_pkg::SRA: result_o = shr_full[ex_pkg::XLEN-1:0];
      // Compare group returns a 0/1 word
      default:     result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// ==== verilog/ex_mult.sv ====
////////////////////////////////////////////////////////////
// MUL is single cycle, high products take MULT_ITERS cycles
// Operands must stay stable until the stage advances
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              multicycle_o,
  output logic              ready_o
);

  ex_pkg::mult_state_e             state_q;
  ex_pkg::mult_state_e             state_d;
  logic [ex_pkg::MULT_CNT_W-1:0]   cnt_q;
  logic                            is_high;
  logic                            start;
  logic                            a_neg;
  logic                            b_neg;
  ex_pkg::word_t                   mag_a;
  ex_pkg::word_t                   mag_b;
  ex_pkg::word_t                   mcand_q;
  logic                            neg_q;
  logic [2*ex_pkg::XLEN-1:0]       acc_q;
  logic [ex_pkg::XLEN:0]           partial;
  logic [2*ex_pkg::XLEN-1:0]       signed_prod;
  ex_pkg::word_t                   prod_lo;

  // Low product straight from the operands
  assign prod_lo = mult_req_i.a * mult_req_i.b;

  assign is_high = (mult_req_i.op != ex_pkg::MUL);
  assign start   = enable_i & is_high & (state_q == ex_pkg::IDLE);

  ////////////////////////////////////////////////////////////
  // Operand magnitudes
  ////////////////////////////////////////////////////////////

  // a is signed for MULH and MULHSU, b only for MULH
  assign a_neg = mult_req_i.a[ex_pkg::XLEN-1] &
                 ((mult_req_i.op == ex_pkg::MULH) || (mult_req_i.op == ex_pkg::MULHSU));
  assign b_neg = mult_req_i.b[ex_pkg::XLEN-1] & (mult_req_i.op == ex_pkg::MULH);

  // Most negative value maps onto its own unsigned magnitude
  assign mag_a = a_neg ? -mult_req_i.a : mult_req_i.a;
  assign mag_b = b_neg ? -mult_req_i.b : mult_req_i.b;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::IDLE: if (start) state_d = ex_pkg::ITER;
      ex_pkg::ITER: if (cnt_q == ex_pkg::MULT_LAST) state_d = ex_pkg::DONE;
      // Hold the result until the stage moves on
      ex_pkg::DONE: if (ex_ready_i) state_d = ex_pkg::IDLE;
      default:      state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Counts iterations, cleared outside ITER
      cnt_q   <= (state_q == ex_pkg::ITER) ? cnt_q + 1'b1 : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Shift-add datapath
  ////////////////////////////////////////////////////////////

  // Upper half plus multiplicand when the current multiplier bit is set
  assign partial = {1'b0, acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN]} +
                   (acc_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk) begin
    if (start) begin
      // Multiplier in the low half, shifted out one bit per step
      acc_q   <= {{ex_pkg::XLEN{1'b0}}, mag_b};
      mcand_q <= mag_a;
      neg_q   <= a_neg ^ b_neg;
    end else if (state_q == ex_pkg::ITER) begin
      acc_q   <= {partial, acc_q[ex_pkg::XLEN-1:1]};
    end
  end

  // Restore the sign of the full product
  assign signed_prod = neg_q ? -acc_q : acc_q;

  assign result_o = is_high ? signed_prod[2*ex_pkg::XLEN-1:ex_pkg::XLEN] : prod_lo;

  // Not ready in the start cycle of a high product either
  assign ready_o = (state_q == ex_pkg::DONE) |
                   ((state_q == ex_pkg::IDLE) & ~(enable_i & is_high));

  assign multicycle_o = (state_q == ex_pkg::ITER);

endmodule

// ==== verilog/ex_wb_port.sv ====
////////////////////////////////////////////////////////////
// Forwarding port is combinational, load port registered
// Load data itself comes straight from the LSU
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_wb_port (
  input  logic              clk,
  input  logic              rst_n,

  // Unit selects
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,

  // Result sources
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,

  // Forwarding port destination
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,

  // Load port destination
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // Stage handshake
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,

  output ex_pkg::rf_wr_t    alu_fw_o,
  output ex_pkg::rf_wr_t    wb_o
);

  logic              lsu_we_q;
  ex_pkg::reg_addr_t lsu_waddr_q;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    // CSR wins over multiplier, multiplier over ALU
    if (csr_access_i) begin
      alu_fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      alu_fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      alu_fw_o.wdata = alu_result_i;
    end else begin
      alu_fw_o.wdata = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB load register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      // Valid already implies WB is ready
      lsu_we_q <= regfile_we_i;
      if (regfile_we_i) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB took the old entry and nothing new came in
      lsu_we_q <= 1'b0;
    end
  end

  assign wb_o.we    = lsu_we_q;
  assign wb_o.waddr = lsu_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// ==== verilog/ex_stage.sv ====
////////////////////////////////////////////////////////////
// Execute stage top, valid goes right and ready goes left
// ID must hold its inputs until ex_ready_o is seen high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU request
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              alu_en_i,

  // Multiplier request
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              mult_en_i,

  // CSR read
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,

  // LSU
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  // EX part of the LSU is done
  input  logic              lsu_ready_ex_i,

  // Destinations
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,

  output ex_pkg::rf_wr_t    alu_fw_o,
  output ex_pkg::rf_wr_t    wb_o,

  // Branch resolution to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,

  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::word_t mult_result;
  logic          mult_ready;
  logic          units_ready;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu alu_inst (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_wb_port wb_port_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .alu_fw_o            (alu_fw_o),
    .wb_o                (wb_o)
  );

  ////////////////////////////////////////////////////////////
  // Branch and stall logic
  ////////////////////////////////////////////////////////////

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.c;

  // ALU never stalls, so it has no term here
  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX without needing WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// ==== verif/ex_clk_gen.sv ====
////////////////////////////////////////////////////////////
// 20 ns clock, reset held low for the first 3 rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the flop updates
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== verif/ex_checker.sv ====
////////////////////////////////////////////////////////////
// Samples DUT outputs on rising edges, before the flops move
// Load port is checked in the two idle cycles after each test
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_checker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           chk_en_i,
  input  logic           summary_i,
  input  int             test_num_i,

  // Expected values of the current entry
  input  logic           is_branch_i,
  input  logic           high_mult_i,
  input  ex_pkg::rf_wr_t exp_fw_i,
  input  ex_pkg::rf_wr_t exp_wb_i,
  input  logic           exp_br_i,
  input  ex_pkg::word_t  exp_target_i,

  // Observed DUT signals
  input  ex_pkg::rf_wr_t alu_fw_i,
  input  ex_pkg::rf_wr_t wb_i,
  input  ex_pkg::word_t  jump_target_i,
  input  logic           branch_decision_i,
  input  logic           mult_multicycle_i,
  input  logic           ex_ready_i,
  input  logic           ex_valid_i,
  input  logic           wb_ready_i,
  input  logic           lsu_ready_ex_i,

  output int             err_cnt_o
);

  // 0 waits for completion, 1 and 2 are the idle cycles
  int             phase;
  int             test_errs;
  int             test_cnt;
  logic           mc_seen;
  logic           stalled;
  logic           done;
  ex_pkg::rf_wr_t wb_prev;

  initial begin
    err_cnt_o = 0;
    phase     = 0;
    test_errs = 0;
    test_cnt  = 0;
    mc_seen   = 1'b0;
  end

  assign stalled = ~wb_ready_i | ~lsu_ready_ex_i;
  // Branch-only entries end on ready, all others on valid
  assign done    = is_branch_i ? ex_ready_i : ex_valid_i;

  task automatic mismatch(input string msg);
    $display("FAIL at %0t: test %0d %s", $time, test_num_i, msg);
    err_cnt_o++;
    test_errs++;
  endtask

  task automatic close_test();
    $display("test %0d finished with %0d mismatches", test_num_i, test_errs);
    test_cnt++;
    test_errs = 0;
    mc_seen   = 1'b0;
    phase     = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle comparison
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      phase = 0;
    end else if (phase == 0 && chk_en_i) begin
      if (mult_multicycle_i) mc_seen = 1'b1;
      // Back-pressure blocks valid and freezes the load register
      if (stalled && ex_valid_i) mismatch("ex_valid_o high during a stall");
      // Only a branch may force ready through a stall
      if (stalled && !is_branch_i && ex_ready_i) mismatch("ex_ready_o high during a stall");
      if (stalled && (wb_i.we !== wb_prev.we || wb_i.waddr !== wb_prev.waddr)) begin
        mismatch($sformatf("wb_o moved during a stall to %h", wb_i));
      end
      if (done) begin
        if (!is_branch_i && alu_fw_i !== exp_fw_i) begin
          mismatch($sformatf("alu_fw_o %h, expected %h", alu_fw_i, exp_fw_i));
        end
        if (mc_seen !== high_mult_i) begin
          mismatch($sformatf("mult_multicycle_o seen %b, expected %b", mc_seen, high_mult_i));
        end
        if (is_branch_i) begin
          if (branch_decision_i !== exp_br_i) begin
            mismatch($sformatf("branch_decision_o %b, expected %b", branch_decision_i, exp_br_i));
          end
          if (jump_target_i !== exp_target_i) begin
            mismatch($sformatf("jump_target_o %h, expected %h", jump_target_i, exp_target_i));
          end
          close_test();
        end else begin
          phase = 1;
        end
      end
    end else if (phase == 1) begin
      // Cycle after valid, waddr only matters with we set
      if (wb_i.we !== exp_wb_i.we || wb_i.wdata !== exp_wb_i.wdata ||
          (exp_wb_i.we && wb_i.waddr !== exp_wb_i.waddr)) begin
        mismatch($sformatf("wb_o %h, expected %h", wb_i, exp_wb_i));
      end
      phase = 2;
    end else if (phase == 2) begin
      if (wb_i.we !== 1'b0) mismatch("wb_o.we still set after an idle cycle");
      close_test();
    end
    wb_prev = wb_i;
  end

  always @(posedge summary_i) begin
    $display("%0d tests run, %0d mismatches", test_cnt, err_cnt_o);
  end

endmodule

// ==== verif/ex_sva.sv ====
////////////////////////////////////////////////////////////
// Handshake and reset rules, bound into every ex_stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                wb_ready_i,
  input logic                ex_valid_i,
  input logic                ex_ready_i,
  input logic                wb_we_i,
  input ex_pkg::mult_state_e mult_state_i
);

  // WB back-pressure always blocks valid
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else $error("ex_valid_o high while wb_ready_i is low");

  // Finished result stays until the stage advances
  done_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_state_i == ex_pkg::DONE && !ex_ready_i) |=> mult_state_i == ex_pkg::DONE)
    else $error("multiplier left DONE without ex_ready_o");

  reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!ex_valid_i && !wb_we_i))
    else $error("ex_valid_o or wb_o.we set right after reset");

endmodule

bind ex_stage ex_sva sva_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_ready_i   (wb_ready_i),
  .ex_valid_i   (ex_valid_o),
  .ex_ready_i   (ex_ready_o),
  .wb_we_i      (wb_o.we),
  .mult_state_i (mult_inst.state_q)
);

// ==== verif/ex_tb.sv ====
////////////////////////////////////////////////////////////
// Table driven, one instruction at a time, RV32 operands only
// Each entry is followed by two idle cycles for the load port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_tb;

  // One table row, stimulus and expected results
  typedef struct packed {
    logic [3:0]        unit;      // {lsu, csr, mult, alu}
    logic              br;
    ex_pkg::alu_op_e   aop;
    ex_pkg::mult_op_e  mop;
    ex_pkg::word_t     a;
    ex_pkg::word_t     b;
    ex_pkg::word_t     c;
    ex_pkg::word_t     csr_d;
    ex_pkg::word_t     lsu_d;
    ex_pkg::rf_wr_t    fw;        // forwarding destination and expected data
    logic              we;
    ex_pkg::reg_addr_t waddr;
    logic [2:0]        stall;     // cycles of back-pressure
    logic              stall_lsu; // stall on LSU instead of WB
    logic              exp_br;
  } entry_t;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_req_t  alu_req;
  ex_pkg::mult_req_t mult_req;
  logic              alu_en;
  logic              mult_en;
  logic              csr_access;
  logic              lsu_en;
  logic              lsu_ready_ex;
  logic              branch_in_ex;
  logic              wb_ready;
  ex_pkg::rf_wr_t    alu_fw;
  ex_pkg::rf_wr_t    wb;
  ex_pkg::word_t     jump_target;
  logic              branch_decision;
  logic              mult_multicycle;
  logic              ex_ready;
  logic              ex_valid;

  entry_t            tests[$];
  entry_t            cur;
  logic              active;
  logic              stall_on;
  logic              chk_en;
  logic              summary;
  int                test_num;
  int                err_cnt;
  int                cycles = 0;
  integer            seed;
  ex_pkg::rf_wr_t    exp_wb;

  ////////////////////////////////////////////////////////////
  // Stimulus from the current entry
  ////////////////////////////////////////////////////////////

  assign alu_req      = {cur.aop, cur.a, cur.b, cur.c};
  assign mult_req     = {cur.mop, cur.a, cur.b};
  assign alu_en       = active & cur.unit[0];
  assign mult_en      = active & cur.unit[1];
  assign csr_access   = active & cur.unit[2];
  assign lsu_en       = active & cur.unit[3];
  assign branch_in_ex = active & cur.br;
  assign wb_ready     = ~(stall_on & ~cur.stall_lsu);
  assign lsu_ready_ex = ~(stall_on & cur.stall_lsu);
  // Load data comes straight through, so wdata is the LSU word
  assign exp_wb       = {cur.we, cur.waddr, cur.lsu_d};

  ex_clk_gen clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage ex_stage_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (cur.csr_d),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (cur.lsu_d),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .regfile_alu_we_i    (cur.fw.we),
    .regfile_alu_waddr_i (cur.fw.waddr),
    .regfile_we_i        (cur.we),
    .regfile_waddr_i     (cur.waddr),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .alu_fw_o            (alu_fw),
    .wb_o                (wb),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  ex_checker checker_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .chk_en_i          (chk_en),
    .summary_i         (summary),
    .test_num_i        (test_num),
    .is_branch_i       (cur.br),
    .high_mult_i       (cur.unit[1] & (cur.mop != ex_pkg::MUL)),
    .exp_fw_i          (cur.fw),
    .exp_wb_i          (exp_wb),
    .exp_br_i          (cur.exp_br),
    .exp_target_i      (cur.c),
    .alu_fw_i          (alu_fw),
    .wb_i              (wb),
    .jump_target_i     (jump_target),
    .branch_decision_i (branch_decision),
    .mult_multicycle_i (mult_multicycle),
    .ex_ready_i        (ex_ready),
    .ex_valid_i        (ex_valid),
    .wb_ready_i        (wb_ready),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .err_cnt_o         (err_cnt)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and table rows
  ////////////////////////////////////////////////////////////

  // Full 64-bit product of the extended operands, then pick a half
  function automatic ex_pkg::word_t expected_product(input ex_pkg::mult_op_e op,
                                                     input ex_pkg::word_t a,
                                                     input ex_pkg::word_t b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'h0, a};
    ub = {32'h0, b};
    case (op)
      ex_pkg::MULH:   p = sa * sb;
      ex_pkg::MULHSU: p = sa * ub;
      default:        p = ua * ub;
    endcase
    return (op == ex_pkg::MUL) ? p[31:0] : p[63:32];
  endfunction

  task automatic alu_entry(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input ex_pkg::word_t exp);
    entry_t e;
    e       = '0;
    e.unit  = 4'b0001;
    e.aop   = op;
    e.a     = a;
    e.b     = b;
    e.fw    = {1'b1, ex_pkg::reg_addr_t'(~op), exp};
    tests.push_back(e);
  endtask

  task automatic branch_entry(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                              input ex_pkg::word_t b, input logic exp, input logic [2:0] stall);
    entry_t e;
    e        = '0;
    e.br     = 1'b1;
    e.aop    = op;
    e.a      = a;
    e.b      = b;
    e.c      = a ^ b;
    e.exp_br = exp;
    e.stall  = stall;
    tests.push_back(e);
  endtask

  task automatic mult_entry(input ex_pkg::mult_op_e op, input ex_pkg::word_t a,
                            input ex_pkg::word_t b);
    entry_t e;
    e      = '0;
    e.unit = 4'b0010;
    e.mop  = op;
    e.a    = a;
    e.b    = b;
    e.fw   = {1'b1, 5'd20, expected_product(op, a, b)};
    tests.push_back(e);
  endtask

  task automatic load_entry(input ex_pkg::reg_addr_t waddr, input ex_pkg::word_t data);
    entry_t e;
    e       = '0;
    e.unit  = 4'b1000;
    e.we    = 1'b1;
    e.waddr = waddr;
    e.lsu_d = data;
    tests.push_back(e);
  endtask

  task automatic fill_table();
    ex_pkg::word_t ra;
    ex_pkg::word_t rb;
    entry_t        e;
    // Negative a, shift amount 20
    alu_entry(ex_pkg::ADD,  32'h8000_0F0F, 32'h0001_0234, 32'h8001_1143);
    alu_entry(ex_pkg::SUB,  32'h8000_0F0F, 32'h0001_0234, 32'h7FFF_0CDB);
    alu_entry(ex_pkg::XOR,  32'h8000_0F0F, 32'h0001_0234, 32'h8001_0D3B);
    alu_entry(ex_pkg::OR,   32'h8000_0F0F, 32'h0001_0234, 32'h8001_0F3F);
    alu_entry(ex_pkg::AND,  32'h8000_0F0F, 32'h0001_0234, 32'h0000_0204);
    alu_entry(ex_pkg::SLL,  32'h8000_0F0F, 32'h0001_0234, 32'hF0F0_0000);
    alu_entry(ex_pkg::SRL,  32'h8000_0F0F, 32'h0001_0234, 32'h0000_0800);
    alu_entry(ex_pkg::SRA,  32'h8000_0F0F, 32'h0001_0234, 32'hFFFF_F800);
    alu_entry(ex_pkg::SLT,  32'h8000_0F0F, 32'h0001_0234, 32'h0000_0001);
    alu_entry(ex_pkg::SLTU, 32'h8000_0F0F, 32'h0001_0234, 32'h0000_0000);
    branch_entry(ex_pkg::EQ,  32'h1234_5678, 32'h1234_5678, 1'b1, 3'd0);
    branch_entry(ex_pkg::EQ,  32'h8000_0F0F, 32'h0001_0234, 1'b0, 3'd0);
    branch_entry(ex_pkg::NE,  32'h8000_0F0F, 32'h0001_0234, 1'b1, 3'd0);
    branch_entry(ex_pkg::LT,  32'h8000_0F0F, 32'h0001_0234, 1'b1, 3'd0);
    branch_entry(ex_pkg::GE,  32'h8000_0F0F, 32'h0001_0234, 1'b0, 3'd0);
    branch_entry(ex_pkg::LTU, 32'h8000_0F0F, 32'h0001_0234, 1'b0, 3'd0);
    // WB stalled, the branch must still leave EX
    branch_entry(ex_pkg::GEU, 32'h8000_0F0F, 32'h0001_0234, 1'b1, 3'd3);
    // Negative times negative and the most negative value
    mult_entry(ex_pkg::MUL,    32'hFFFF_FFFD, 32'hFFFF_FFFB);
    mult_entry(ex_pkg::MULH,   32'hFFFF_FFFD, 32'hFFFF_FFFB);
    mult_entry(ex_pkg::MULH,   32'h8000_0000, 32'h8000_0000);
    mult_entry(ex_pkg::MULHSU, 32'h8000_0000, 32'hFFFF_FFFF);
    mult_entry(ex_pkg::MULHU,  32'h8000_0000, 32'h8000_0000);
    for (int r = 0; r < 8; r++) begin
      ra = $random(seed);
      rb = $random(seed);
      mult_entry(ex_pkg::mult_op_e'(r % 4), ra, rb);
    end
    // CSR read wins over the ALU result
    e       = '0;
    e.unit  = 4'b0101;
    e.a     = 32'h0000_0011;
    e.b     = 32'h0000_0022;
    e.csr_d = 32'hC5A0_1234;
    e.fw    = {1'b1, 5'd7, 32'hC5A0_1234};
    tests.push_back(e);
    load_entry(5'd9, 32'h1357_9BDF);
    // Held by WB, then by the LSU
    load_entry(5'd14, 32'h2468_ACE0);
    tests[$].stall = 3'd4;
    alu_entry(ex_pkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000);
    tests[$].stall     = 3'd3;
    tests[$].stall_lsu = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Driving loop
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 32'ha1df_8f18;
    cur      = '0;
    active   = 1'b0;
    stall_on = 1'b0;
    chk_en   = 1'b0;
    summary  = 1'b0;
    test_num = 0;
    fill_table();
    @(posedge rst_n);
    foreach (tests[i]) begin
      @(negedge clk);
      cur      = tests[i];
      test_num = i;
      active   = 1'b1;
      chk_en   = 1'b1;
      stall_on = (tests[i].stall != 3'd0);
      // Branches keep the stall to show that ready is forced
      if (stall_on && !cur.br) begin
        repeat (cur.stall) @(posedge clk);
        @(negedge clk);
        stall_on = 1'b0;
      end
      do @(posedge clk); while (!(cur.br ? ex_ready : ex_valid));
      @(negedge clk);
      active   = 1'b0;
      chk_en   = 1'b0;
      stall_on = 1'b0;
      repeat (2) @(posedge clk);
    end
    summary = 1'b1;
    #1;
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Longest entry is a high product plus the idle cycles
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > tests.size() * (ex_pkg::MULT_ITERS + 8)) begin
      $display("Run timed out after %0d cycles, the DUT stopped completing", cycles);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_wb_port.sv
verilog/ex_stage.sv
verif/ex_clk_gen.sv
verif/ex_checker.sv
verif/ex_sva.sv
verif/ex_tb.sv
